// ==== list.f ====
verilog/cpu_pkg.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/retire_unit.sv
verilog/execute_stage.sv
verilog/cpu_core.sv
verification/tb_cpu_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cpu_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_cpu_core -f list.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_cpu_core)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

// ==== verification/golden_trace.txt ====
# tag hex: I = instruction word in order, E = expected WWD word in order
# N = expected num_inst after halt (every I line, hlt included)
I 6112 # lhi r1 0x12        r1 = 1200
I 5534 # ori r1 r1 0x34     r1 = 1234
I F41C # wwd r1
I 46FE # adi r2 r1 -2       r2 = 1232
I F81C # wwd r2
I F6C0 # add r3 r1 r2       r3 = 2466
I FC1C # wwd r3
I F901 # sub r0 r2 r1       r0 = fffe
I F01C # wwd r0
I F7C2 # and r3 r1 r3       r3 = 0024
I FC1C # wwd r3
I FB83 # orr r2 r2 r3       r2 = 1236
I F81C # wwd r2
I F444 # not r1 r1          r1 = edcb
I F41C # wwd r1
I F005 # tcp r0 r0          r0 = 0002
I F01C # wwd r0
I F4C6 # shl r3 r1          r3 = db96
I FC1C # wwd r3
I F487 # shr r2 r1          r2 = f6e5
I F81C # wwd r2
I 0000 # unknown opcode, no-op
I 407F # adi r0 r0 0x7f     r0 = 0081
I F000 # add r0 r0 r0       r0 = 0102
I F01C # wwd r0
I F01D # hlt
E 1234
E 1232
E 2466
E FFFE
E 0024
E 1236
E EDCB
E 0002
E DB96
E F6E5
E 0102
N 001A

// ==== verification/tb_cpu_core.sv ====
`timescale 1ns/1ns

module tb_cpu_core;

    localparam int max_cycles = 2000;

    logic           clk;
    logic           reset_n;
    logic           in_valid;
    cpu_pkg::word_t in_instr;
    logic           in_ready;
    logic           out_valid;
    cpu_pkg::word_t out_data;
    logic           out_ready;
    cpu_pkg::word_t num_inst;
    logic           is_halted;

    cpu_pkg::word_t instr_q[$];
    cpu_pkg::word_t expect_q[$];
    cpu_pkg::word_t expect_count;
    int             mismatches;
    int             failures;

    cpu_core u_dut (
        .clk(clk), .reset_n(reset_n),
        .in_valid(in_valid), .in_instr(in_instr), .in_ready(in_ready),
        .out_valid(out_valid), .out_data(out_data), .out_ready(out_ready),
        .num_inst(num_inst), .is_halted(is_halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input cpu_pkg::word_t exp,
                               input cpu_pkg::word_t got);
        assert (got === exp) else begin
            mismatches++;
            $display("Mismatch %s exp 0x%04h got 0x%04h", name, exp, got);
        end
    endtask

    //////////////////////////////
    // golden trace
    task automatic load_trace;
        int             fd;
        int             code;
        string          line;
        cpu_pkg::word_t value;
        fd = $fopen("verification/golden_trace.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("could not open the golden trace file");
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0) break;
            if (line.len() < 3 || line.getc(0) == "#") continue;
            code = $sscanf(line.substr(2, line.len() - 1), "%h", value);
            case (line.getc(0))
                "I": instr_q.push_back(value);
                "E": expect_q.push_back(value);
                "N": expect_count = value;
                default: ;
            endcase
        end
        $fclose(fd);
    endtask

    //////////////////////////////
    // stimulus and monitor
    initial begin
        int unsigned seed_val;
        int          idx;
        int          got;
        int          cycles;
        logic        in_fire;
        logic        out_fire;

        seed_val     = $urandom(20482);
        reset_n      = 1'b1;
        in_valid     = 1'b0;
        in_instr     = '0;
        out_ready    = 1'b0;
        mismatches   = 0;
        failures     = 0;
        expect_count = '0;
        load_trace();

        repeat (3) begin
            @(posedge clk);
            #1;
            assert (!out_valid && !in_ready && !is_halted) else begin
                failures++;
                $display("outputs not idle during reset");
            end
            check_value("num_inst", 16'h0000, num_inst);
        end
        reset_n = 1'b0;

        idx    = 0;
        got    = 0;
        cycles = 0;
        while (!(idx == instr_q.size() && is_halted && got == expect_q.size())
               && cycles < max_cycles) begin
            @(negedge clk);
            in_fire  = in_valid && in_ready;
            out_fire = out_valid && out_ready;
            assert (!(out_valid && !out_ready && in_ready)) else begin
                failures++;
                $display("in_ready high while the WWD output is stalled");
            end
            if (out_fire) begin
                if (got < expect_q.size()) begin
                    check_value("out_data", expect_q[got], out_data);
                end else begin
                    failures++;
                    $display("more WWD words than the trace expects");
                end
                got++;
            end

            @(posedge clk);
            #1;
            if (in_fire) begin
                idx++;
                in_valid = 1'b0;
            end
            if (idx < instr_q.size() && !in_valid) begin
                in_valid = ($urandom % 4) != 0;     // random gaps
                in_instr = instr_q[idx];
            end
            out_ready = ($urandom % 10) >= 3;       // low about 30%
            cycles++;
        end

        if (cycles >= max_cycles) begin
            failures++;
            $display("timeout: trace not finished or core not halted");
        end

        // halted core stays quiet
        repeat (5) begin
            @(negedge clk);
            assert (!in_ready && !out_valid && is_halted) else begin
                failures++;
                $display("core not idle after halt");
            end
        end
        check_value("num_inst", expect_count, num_inst);

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verilog/cpu_core.sv ====
`timescale 1ns/1ns

module cpu_core (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           in_valid,
    input  cpu_pkg::word_t in_instr,
    output logic           in_ready,
    output logic           out_valid,
    output cpu_pkg::word_t out_data,
    input  logic           out_ready,
    output cpu_pkg::word_t num_inst,
    output logic           is_halted
);

    // decode to execute
    logic               d_valid;
    cpu_pkg::alu_op_e   d_alu_op;
    cpu_pkg::reg_addr_t d_rs;
    cpu_pkg::reg_addr_t d_rt;
    cpu_pkg::reg_addr_t d_dest;
    logic               d_write;
    cpu_pkg::word_t     d_imm;
    logic               d_wwd;
    logic               d_hlt;

    // operands
    cpu_pkg::word_t     rf_a;
    cpu_pkg::word_t     rf_b;
    logic               bypass_a_hit;
    cpu_pkg::word_t     bypass_a;
    logic               bypass_b_hit;
    cpu_pkg::word_t     bypass_b;

    // execute to retire
    logic               hold;
    logic               x_valid;
    cpu_pkg::reg_addr_t x_dest;
    logic               x_write;
    cpu_pkg::word_t     x_result;
    logic               x_hlt;

    // regfile write
    logic               wr_en;
    cpu_pkg::reg_addr_t wr_addr;
    cpu_pkg::word_t     wr_data;

    decode_stage u_decode (
        .clk(clk), .reset_n(reset_n),
        .in_valid(in_valid), .in_instr(in_instr), .hold(hold), .is_halted(is_halted),
        .in_ready(in_ready), .d_valid(d_valid), .d_alu_op(d_alu_op),
        .d_rs(d_rs), .d_rt(d_rt), .d_dest(d_dest), .d_write(d_write),
        .d_imm(d_imm), .d_wwd(d_wwd), .d_hlt(d_hlt)
    );

    register_file u_regfile (
        .clk(clk), .reset_n(reset_n),
        .rd_addr_a(d_rs), .rd_addr_b(d_rt),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .rf_a(rf_a), .rf_b(rf_b)
    );

    retire_unit u_retire (
        .clk(clk), .reset_n(reset_n), .hold(hold),
        .x_valid(x_valid), .x_dest(x_dest), .x_write(x_write),
        .x_result(x_result), .x_hlt(x_hlt), .d_rs(d_rs), .d_rt(d_rt),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .bypass_a_hit(bypass_a_hit), .bypass_a(bypass_a),
        .bypass_b_hit(bypass_b_hit), .bypass_b(bypass_b),
        .num_inst(num_inst), .is_halted(is_halted)
    );

    execute_stage u_execute (
        .clk(clk), .reset_n(reset_n),
        .d_valid(d_valid), .d_alu_op(d_alu_op), .d_rs(d_rs), .d_rt(d_rt),
        .d_dest(d_dest), .d_write(d_write), .d_imm(d_imm), .d_wwd(d_wwd), .d_hlt(d_hlt),
        .rf_a(rf_a), .rf_b(rf_b),
        .bypass_a_hit(bypass_a_hit), .bypass_a(bypass_a),
        .bypass_b_hit(bypass_b_hit), .bypass_b(bypass_b),
        .out_ready(out_ready), .hold(hold),
        .x_valid(x_valid), .x_dest(x_dest), .x_write(x_write),
        .x_result(x_result), .x_hlt(x_hlt),
        .out_valid(out_valid), .out_data(out_data)
    );

endmodule

// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

    //////////////////////////////
    // widths
    localparam int word_w     = 16;
    localparam int reg_addr_w = 2;
    localparam int imm_w      = 8;

    // instruction fields
    localparam int opcode_msb = 15;
    localparam int opcode_lsb = 12;
    localparam int rs_msb     = 11;
    localparam int rs_lsb     = 10;
    localparam int rt_msb     = 9;
    localparam int rt_lsb     = 8;
    localparam int rd_msb     = 7;
    localparam int rd_lsb     = 6;
    localparam int funct_msb  = 5;
    localparam int funct_lsb  = 0;

    typedef logic [word_w-1:0]     word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    //////////////////////////////
    // encodings
    typedef enum logic [3:0] {
        op_adi   = 4'd4,    // rt = rs + sext(imm)
        op_ori   = 4'd5,    // rt = rs | zext(imm)
        op_lhi   = 4'd6,    // rt = imm << 8
        op_rtype = 4'd15
    } opcode_e;

    typedef enum logic [5:0] {
        fn_add = 6'd0,
        fn_sub = 6'd1,
        fn_and = 6'd2,
        fn_orr = 6'd3,
        fn_not = 6'd4,
        fn_tcp = 6'd5,      // two's complement
        fn_shl = 6'd6,
        fn_shr = 6'd7,      // arithmetic
        fn_wwd = 6'd28,
        fn_hlt = 6'd29
    } funct_e;

    // ops handed from decode to execute
    typedef enum logic [3:0] {
        alu_none,
        alu_add,
        alu_sub,
        alu_and,
        alu_orr,
        alu_not,
        alu_tcp,
        alu_shl,
        alu_shr,
        alu_adi,
        alu_ori,
        alu_lhi
    } alu_op_e;

endpackage

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               in_valid,
    input  cpu_pkg::word_t     in_instr,
    input  logic               hold,
    input  logic               is_halted,
    output logic               in_ready,
    output logic               d_valid,
    output cpu_pkg::alu_op_e   d_alu_op,
    output cpu_pkg::reg_addr_t d_rs,
    output cpu_pkg::reg_addr_t d_rt,
    output cpu_pkg::reg_addr_t d_dest,
    output logic               d_write,
    output cpu_pkg::word_t     d_imm,
    output logic               d_wwd,
    output logic               d_hlt
);

    cpu_pkg::opcode_e   opcode;
    cpu_pkg::funct_e    funct;
    logic [cpu_pkg::imm_w-1:0] imm_field;
    cpu_pkg::alu_op_e   alu_op;
    cpu_pkg::reg_addr_t dest;
    cpu_pkg::word_t     imm;
    logic               write;
    logic               wwd;
    logic               hlt;
    logic               run;    // low until the first cycle out of reset
    logic               accept;

    assign opcode    = cpu_pkg::opcode_e'(in_instr[cpu_pkg::opcode_msb:cpu_pkg::opcode_lsb]);
    assign funct     = cpu_pkg::funct_e'(in_instr[cpu_pkg::funct_msb:cpu_pkg::funct_lsb]);
    assign imm_field = in_instr[cpu_pkg::imm_w-1:0];

    assign in_ready = run && !hold && !is_halted;
    assign accept   = in_valid && in_ready;

    always_comb begin
        alu_op = cpu_pkg::alu_none;
        dest   = in_instr[cpu_pkg::rt_msb:cpu_pkg::rt_lsb];
        imm    = {{(cpu_pkg::word_w-cpu_pkg::imm_w){imm_field[cpu_pkg::imm_w-1]}}, imm_field};
        wwd    = 1'b0;
        hlt    = 1'b0;
        case (opcode)
            cpu_pkg::op_adi: alu_op = cpu_pkg::alu_adi;
            cpu_pkg::op_ori: begin
                alu_op = cpu_pkg::alu_ori;
                imm    = {{(cpu_pkg::word_w-cpu_pkg::imm_w){1'b0}}, imm_field};
            end
            cpu_pkg::op_lhi: begin
                alu_op = cpu_pkg::alu_lhi;
                imm    = {imm_field, {(cpu_pkg::word_w-cpu_pkg::imm_w){1'b0}}};
            end
            cpu_pkg::op_rtype: begin
                dest = in_instr[cpu_pkg::rd_msb:cpu_pkg::rd_lsb];
                case (funct)
                    cpu_pkg::fn_add: alu_op = cpu_pkg::alu_add;
                    cpu_pkg::fn_sub: alu_op = cpu_pkg::alu_sub;
                    cpu_pkg::fn_and: alu_op = cpu_pkg::alu_and;
                    cpu_pkg::fn_orr: alu_op = cpu_pkg::alu_orr;
                    cpu_pkg::fn_not: alu_op = cpu_pkg::alu_not;
                    cpu_pkg::fn_tcp: alu_op = cpu_pkg::alu_tcp;
                    cpu_pkg::fn_shl: alu_op = cpu_pkg::alu_shl;
                    cpu_pkg::fn_shr: alu_op = cpu_pkg::alu_shr;
                    cpu_pkg::fn_wwd: wwd = 1'b1;
                    cpu_pkg::fn_hlt: hlt = 1'b1;
                    default: ;      // no-op that still retires and counts
                endcase
            end
            default: ;
        endcase
        write = (alu_op != cpu_pkg::alu_none);
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            run     <= 1'b0;
            d_valid <= 1'b0;
        end else begin
            run <= 1'b1;
            if (!hold) begin
                d_valid <= accept;
            end
        end
    end

    // decoded fields qualified by d_valid
    always_ff @(posedge clk) begin
        if (accept) begin
            d_alu_op <= alu_op;
            d_rs     <= in_instr[cpu_pkg::rs_msb:cpu_pkg::rs_lsb];
            d_rt     <= in_instr[cpu_pkg::rt_msb:cpu_pkg::rt_lsb];
            d_dest   <= dest;
            d_write  <= write;
            d_imm    <= imm;
            d_wwd    <= wwd;
            d_hlt    <= hlt;
        end
    end

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               d_valid,
    input  cpu_pkg::alu_op_e   d_alu_op,
    input  cpu_pkg::reg_addr_t d_rs,
    input  cpu_pkg::reg_addr_t d_rt,
    input  cpu_pkg::reg_addr_t d_dest,
    input  logic               d_write,
    input  cpu_pkg::word_t     d_imm,
    input  logic               d_wwd,
    input  logic               d_hlt,
    input  cpu_pkg::word_t     rf_a,
    input  cpu_pkg::word_t     rf_b,
    input  logic               bypass_a_hit,
    input  cpu_pkg::word_t     bypass_a,
    input  logic               bypass_b_hit,
    input  cpu_pkg::word_t     bypass_b,
    input  logic               out_ready,
    output logic               hold,
    output logic               x_valid,
    output cpu_pkg::reg_addr_t x_dest,
    output logic               x_write,
    output cpu_pkg::word_t     x_result,
    output logic               x_hlt,
    output logic               out_valid,
    output cpu_pkg::word_t     out_data
);

    cpu_pkg::word_t op_a;
    cpu_pkg::word_t op_b;
    cpu_pkg::word_t alu_out;
    logic           load_out;

    //////////////////////////////
    // operand select
    assign op_a = bypass_a_hit ? bypass_a : rf_a;
    assign op_b = bypass_b_hit ? bypass_b : rf_b;

    //////////////////////////////
    // alu
    always_comb begin
        case (d_alu_op)
            cpu_pkg::alu_add: alu_out = op_a + op_b;
            cpu_pkg::alu_sub: alu_out = op_a - op_b;
            cpu_pkg::alu_and: alu_out = op_a & op_b;
            cpu_pkg::alu_orr: alu_out = op_a | op_b;
            cpu_pkg::alu_not: alu_out = ~op_a;
            cpu_pkg::alu_tcp: alu_out = ~op_a + 1'b1;
            cpu_pkg::alu_shl: alu_out = {op_a[cpu_pkg::word_w-2:0], 1'b0};
            cpu_pkg::alu_shr: alu_out = {op_a[cpu_pkg::word_w-1], op_a[cpu_pkg::word_w-1:1]};
            cpu_pkg::alu_adi: alu_out = op_a + d_imm;
            cpu_pkg::alu_ori: alu_out = op_a | d_imm;
            cpu_pkg::alu_lhi: alu_out = d_imm;
            default:          alu_out = '0;
        endcase
    end

    assign x_valid  = d_valid;
    assign x_dest   = d_dest;
    assign x_write  = d_write;
    assign x_result = alu_out;
    assign x_hlt    = d_hlt;

    //////////////////////////////
    // wwd output register
    assign hold     = out_valid && !out_ready;  // freezes every stage
    assign load_out = !hold && d_valid && d_wwd;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            out_valid <= 1'b0;
        end else if (!hold) begin
            out_valid <= d_valid && d_wwd;  // old word left on this edge if it was valid
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            out_data <= op_a;
        end
    end

endmodule

// ==== verilog/register_file.sv ====
`timescale 1ns/1ns

module register_file (
    input  logic               clk,
    input  logic               reset_n,
    input  cpu_pkg::reg_addr_t rd_addr_a,
    input  cpu_pkg::reg_addr_t rd_addr_b,
    input  logic               wr_en,
    input  cpu_pkg::reg_addr_t wr_addr,
    input  cpu_pkg::word_t     wr_data,
    output cpu_pkg::word_t     rf_a,
    output cpu_pkg::word_t     rf_b
);

    localparam int num_regs = 2 ** cpu_pkg::reg_addr_w;

    cpu_pkg::word_t regs [num_regs];

    // combinational reads see the old value on a same-edge write
    assign rf_a = regs[rd_addr_a];
    assign rf_b = regs[rd_addr_b];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

// ==== verilog/retire_unit.sv ====
`timescale 1ns/1ns

module retire_unit (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               hold,
    input  logic               x_valid,
    input  cpu_pkg::reg_addr_t x_dest,
    input  logic               x_write,
    input  cpu_pkg::word_t     x_result,
    input  logic               x_hlt,
    input  cpu_pkg::reg_addr_t d_rs,
    input  cpu_pkg::reg_addr_t d_rt,
    output logic               wr_en,
    output cpu_pkg::reg_addr_t wr_addr,
    output cpu_pkg::word_t     wr_data,
    output logic               bypass_a_hit,
    output cpu_pkg::word_t     bypass_a,
    output logic               bypass_b_hit,
    output cpu_pkg::word_t     bypass_b,
    output cpu_pkg::word_t     num_inst,
    output logic               is_halted
);

    logic               r_valid;
    logic               r_write;
    logic               r_hlt;
    cpu_pkg::reg_addr_t r_dest;
    cpu_pkg::word_t     r_result;
    logic               retire;

    assign retire = r_valid && !hold;   // one write and one count per instruction

    assign wr_en   = retire && r_write;
    assign wr_addr = r_dest;
    assign wr_data = r_result;

    //////////////////////////////
    // bypass to execute
    assign bypass_a_hit = r_valid && r_write && (r_dest == d_rs);
    assign bypass_b_hit = r_valid && r_write && (r_dest == d_rt);
    assign bypass_a     = r_result;
    assign bypass_b     = r_result;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            r_valid   <= 1'b0;
            num_inst  <= '0;
            is_halted <= 1'b0;
        end else if (!hold) begin
            // anything behind HLT is dropped
            r_valid <= x_valid && !is_halted && !(r_valid && r_hlt);
            if (retire) begin
                num_inst <= num_inst + 1'b1;
            end
            if (retire && r_hlt) begin
                is_halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            r_dest   <= x_dest;
            r_write  <= x_write;
            r_hlt    <= x_hlt;
            r_result <= x_result;
        end
    end

endmodule
